// ==== decode_stage.f ====
hw/isa_pkg.sv
hw/ctrl_if.sv
hw/control.sv
hw/sign_extend.sv
hw/reg_file.sv
hw/decode.sv
verif/tb_decode.sv

// ==== hw/control.sv ====
// Combinational opcode decoder with no state. Outputs follow instr directly.
// siic and rti are not implemented and only raise err.
// Subtraction inverts operand A, so subi computes imm - Rs.
`timescale 1ns/1ps

module control (
    input  logic [isa_pkg::data_w-1:0] instr,
    ctrl_if.ctrl                       ctl
);
    import isa_pkg::*;

    opcode_t    opcode;
    logic [1:0] func;

    assign opcode = opcode_t'(instr[15:11]);
    assign func   = instr[1:0];

    always_comb begin
        ctl.br_cnd_sel    = instr[12:11];  // Only meaningful for branches.
        ctl.set_sel       = set_eq;
        ctl.wr_en         = 1'b1;
        ctl.mem_wr_en     = 1'b0;
        ctl.mem_en        = 1'b0;
        ctl.wr_sel        = wb_alu;
        ctl.wr_reg_sel    = dst_rd_r;
        ctl.oprnd_sel     = 1'b0;
        ctl.jmp_reg_instr = 1'b0;
        ctl.jmp_instr     = 1'b0;
        ctl.br_instr      = 1'b0;
        ctl.sext_op       = sx_sign5;
        ctl.alu_op        = alu_add;
        ctl.alu_inv_a     = 1'b0;
        ctl.alu_inv_b     = 1'b0;
        ctl.alu_cin       = 1'b0;
        ctl.alu_sign      = 1'b0;
        ctl.pc_en         = 1'b1;
        ctl.err           = 1'b0;

        case (opcode)
            op_halt: begin
                ctl.wr_en = 1'b0;
                ctl.pc_en = 1'b0;  // Freeze fetch.
            end
            op_nop: ctl.wr_en = 1'b0;
            op_siic, op_rti: ctl.err = 1'b1;
            op_addi: begin
                ctl.wr_reg_sel = dst_rd_i;
                ctl.oprnd_sel  = 1'b1;
            end
            op_subi: begin
                ctl.wr_reg_sel = dst_rd_i;
                ctl.oprnd_sel  = 1'b1;
                ctl.alu_inv_a  = 1'b1;  // Two's complement of Rs.
                ctl.alu_cin    = 1'b1;
            end
            op_xori: begin
                ctl.wr_reg_sel = dst_rd_i;
                ctl.oprnd_sel  = 1'b1;
                ctl.sext_op    = sx_zero5;
                ctl.alu_op     = alu_xor;
            end
            op_andni: begin
                ctl.wr_reg_sel = dst_rd_i;
                ctl.oprnd_sel  = 1'b1;
                ctl.sext_op    = sx_zero5;
                ctl.alu_op     = alu_and;
                ctl.alu_inv_b  = 1'b1;
            end
            op_roli, op_slli, op_rori, op_srli: begin
                ctl.wr_reg_sel = dst_rd_i;
                ctl.oprnd_sel  = 1'b1;
                ctl.sext_op    = sx_zero5;
                ctl.alu_op     = alu_op_t'({1'b0, instr[12:11]});  // Same order as alu_op_t.
            end
            op_st: begin
                ctl.wr_en     = 1'b0;
                ctl.mem_en    = 1'b1;
                ctl.mem_wr_en = 1'b1;
                ctl.oprnd_sel = 1'b1;
            end
            op_ld: begin
                ctl.mem_en     = 1'b1;
                ctl.oprnd_sel  = 1'b1;
                ctl.wr_reg_sel = dst_rd_i;
                ctl.wr_sel     = wb_mem;
            end
            op_stu: begin
                ctl.mem_en     = 1'b1;
                ctl.mem_wr_en  = 1'b1;
                ctl.oprnd_sel  = 1'b1;
                ctl.wr_reg_sel = dst_rs;  // Updated address goes back to Rs.
            end
            op_btr: ctl.wr_sel = wb_btr;
            op_alu_r: begin
                case (func)
                    2'b00: ctl.alu_op = alu_add;
                    2'b01: begin
                        ctl.alu_inv_a = 1'b1;  // Rt - Rs.
                        ctl.alu_cin   = 1'b1;
                    end
                    2'b10: ctl.alu_op = alu_xor;
                    2'b11: begin
                        ctl.alu_op    = alu_and;
                        ctl.alu_inv_b = 1'b1;
                    end
                endcase
            end
            op_shift_r: ctl.alu_op = alu_op_t'({1'b0, func});
            op_seq, op_slt, op_sle: begin
                ctl.wr_sel    = wb_set;
                ctl.set_sel   = set_sel_t'(instr[12:11]);
                ctl.alu_inv_b = 1'b1;  // Rs - Rt with signed flags.
                ctl.alu_cin   = 1'b1;
                ctl.alu_sign  = 1'b1;
            end
            op_sco: begin
                ctl.wr_sel  = wb_set;
                ctl.set_sel = set_co;  // Carry out of a plain add.
            end
            op_beqz, op_bnez, op_bltz, op_bgez: begin
                ctl.wr_en    = 1'b0;
                ctl.br_instr = 1'b1;
                ctl.sext_op  = sx_sign8;
            end
            op_lbi: begin
                ctl.wr_sel     = wb_imm;
                ctl.wr_reg_sel = dst_rs;
                ctl.oprnd_sel  = 1'b1;
                ctl.sext_op    = sx_sign8;
            end
            op_slbi: begin
                ctl.wr_sel     = wb_slbi;
                ctl.wr_reg_sel = dst_rs;
                ctl.oprnd_sel  = 1'b1;
                ctl.sext_op    = sx_zero8;
            end
            op_j: begin
                ctl.wr_en     = 1'b0;
                ctl.jmp_instr = 1'b1;
                ctl.sext_op   = sx_sign11;
            end
            op_jr: begin
                ctl.wr_en         = 1'b0;
                ctl.jmp_reg_instr = 1'b1;
                ctl.sext_op       = sx_sign8;
            end
            op_jal: begin
                ctl.jmp_instr  = 1'b1;
                ctl.wr_sel     = wb_pc2;  // Return address into r7.
                ctl.wr_reg_sel = dst_r7;
                ctl.sext_op    = sx_sign11;
            end
            op_jalr: begin
                ctl.jmp_reg_instr = 1'b1;
                ctl.wr_sel        = wb_pc2;
                ctl.wr_reg_sel    = dst_r7;
                ctl.sext_op       = sx_sign8;
            end
        endcase
    end

endmodule

// ==== hw/ctrl_if.sv ====
// Control bundle from the opcode decoder to the decode stage.
// Purely combinational, so there is no clock in the interface.
`timescale 1ns/1ps

interface ctrl_if;
    import isa_pkg::*;

    logic [1:0]  br_cnd_sel;     // Branch condition, taken from the opcode.
    set_sel_t    set_sel;
    logic        wr_en;          // Register file write for this instruction.
    logic        mem_wr_en;
    logic        mem_en;
    wr_sel_t     wr_sel;         // Writeback source.
    wr_reg_sel_t wr_reg_sel;
    logic        oprnd_sel;      // High picks the immediate as operand two.
    logic        jmp_reg_instr;
    logic        jmp_instr;
    logic        br_instr;
    sext_op_t    sext_op;
    alu_op_t     alu_op;
    logic        alu_inv_a;
    logic        alu_inv_b;
    logic        alu_cin;
    logic        alu_sign;
    logic        pc_en;          // Low stops the PC on halt.
    logic        err;

    modport ctrl (
        output br_cnd_sel, set_sel, wr_en, mem_wr_en, mem_en, wr_sel, wr_reg_sel,
               oprnd_sel, jmp_reg_instr, jmp_instr, br_instr, sext_op, alu_op,
               alu_inv_a, alu_inv_b, alu_cin, alu_sign, pc_en, err
    );

    modport stage (
        input br_cnd_sel, set_sel, wr_en, mem_wr_en, mem_en, wr_sel, wr_reg_sel,
              oprnd_sel, jmp_reg_instr, jmp_instr, br_instr, sext_op, alu_op,
              alu_inv_a, alu_inv_b, alu_cin, alu_sign, pc_en, err
    );

endinterface

// ==== hw/decode.sv ====
// Decode stage top. All outputs are combinational in instr and the
// register contents. The write port is driven from outside, standing
// in for writeback. err only flags the unsupported siic and rti.
`timescale 1ns/1ps

module decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [isa_pkg::data_w-1:0]     instr,
    input  logic [isa_pkg::reg_addr_w-1:0] rd_reg_1,
    input  logic [isa_pkg::reg_addr_w-1:0] rd_reg_2,
    input  logic                           in_wr_en,
    input  logic [isa_pkg::reg_addr_w-1:0] in_wr_reg,
    input  logic [isa_pkg::data_w-1:0]     wr_data,
    output logic [isa_pkg::data_w-1:0]     rd_data_1,
    output logic [isa_pkg::data_w-1:0]     rd_data_2,
    output logic [isa_pkg::data_w-1:0]     oprnd_2,
    output logic [isa_pkg::data_w-1:0]     sext_imm,
    output logic [1:0]                     br_cnd_sel,
    output logic [1:0]                     set_sel,
    output logic                           out_wr_en,
    output logic [isa_pkg::reg_addr_w-1:0] out_wr_reg,
    output logic                           mem_wr_en,
    output logic                           mem_en,
    output logic [2:0]                     wr_sel,
    output logic                           jmp_reg_instr,
    output logic                           jmp_instr,
    output logic                           br_instr,
    output logic [2:0]                     alu_op,
    output logic                           alu_inv_a,
    output logic                           alu_inv_b,
    output logic                           alu_cin,
    output logic                           alu_sign,
    output logic                           pc_en,
    output logic                           err
);
    import isa_pkg::*;

    ctrl_if ctl ();

    control u_control (.instr(instr), .ctl(ctl.ctrl));

    sign_extend u_sign_extend (.instr(instr), .sext_op(ctl.sext_op), .imm(sext_imm));

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr_1(rd_reg_1),
        .rd_addr_2(rd_reg_2),
        .wr_addr  (in_wr_reg),
        .wr_en    (in_wr_en),
        .wr_data  (wr_data),
        .rd_data_1(rd_data_1),
        .rd_data_2(rd_data_2)
    );

    always_comb begin
        case (ctl.wr_reg_sel)
            dst_rd_r: out_wr_reg = instr[4:2];
            dst_rd_i: out_wr_reg = instr[7:5];
            dst_rs:   out_wr_reg = instr[10:8];
            default:  out_wr_reg = reg_addr_w'(7);  // Link register for jal and jalr.
        endcase
    end

    assign oprnd_2 = ctl.oprnd_sel ? sext_imm : rd_data_2;  // Immediate for I-format.

    assign br_cnd_sel    = ctl.br_cnd_sel;
    assign set_sel       = ctl.set_sel;
    assign out_wr_en     = ctl.wr_en;
    assign mem_wr_en     = ctl.mem_wr_en;
    assign mem_en        = ctl.mem_en;
    assign wr_sel        = ctl.wr_sel;
    assign jmp_reg_instr = ctl.jmp_reg_instr;
    assign jmp_instr     = ctl.jmp_instr;
    assign br_instr      = ctl.br_instr;
    assign alu_op        = ctl.alu_op;
    assign alu_inv_a     = ctl.alu_inv_a;
    assign alu_inv_b     = ctl.alu_inv_b;
    assign alu_cin       = ctl.alu_cin;
    assign alu_sign      = ctl.alu_sign;
    assign pc_en         = ctl.pc_en;
    assign err           = ctl.err;

endmodule

// ==== hw/isa_pkg.sv ====
// Shared ISA definitions for the 16-bit, eight-register decode stage.
// Opcodes live in instr[15:11]. The R-format function code is instr[1:0].
// Every 5-bit opcode value is a member of opcode_t.
package isa_pkg;

    localparam int data_w     = 16;
    localparam int reg_addr_w = 3;
    localparam int num_regs   = 8;

    typedef enum logic [4:0] {
        op_halt    = 5'b00000,
        op_nop     = 5'b00001,
        op_siic    = 5'b00010,  // Not supported, flagged on err.
        op_rti     = 5'b00011,  // Not supported, flagged on err.
        op_j       = 5'b00100,
        op_jr      = 5'b00101,
        op_jal     = 5'b00110,
        op_jalr    = 5'b00111,
        op_addi    = 5'b01000,
        op_subi    = 5'b01001,
        op_xori    = 5'b01010,
        op_andni   = 5'b01011,
        op_beqz    = 5'b01100,
        op_bnez    = 5'b01101,
        op_bltz    = 5'b01110,
        op_bgez    = 5'b01111,
        op_st      = 5'b10000,
        op_ld      = 5'b10001,
        op_slbi    = 5'b10010,
        op_stu     = 5'b10011,
        op_roli    = 5'b10100,
        op_slli    = 5'b10101,
        op_rori    = 5'b10110,
        op_srli    = 5'b10111,
        op_lbi     = 5'b11000,
        op_btr     = 5'b11001,
        op_shift_r = 5'b11010,
        op_alu_r   = 5'b11011,
        op_seq     = 5'b11100,
        op_slt     = 5'b11101,
        op_sle     = 5'b11110,
        op_sco     = 5'b11111
    } opcode_t;

    // Shift operations share the low encodings with the shift function code.
    typedef enum logic [2:0] {
        alu_rol, alu_sll, alu_ror, alu_srl, alu_add, alu_and, alu_or, alu_xor
    } alu_op_t;

    typedef enum logic [2:0] {
        sx_zero5, sx_sign5, sx_zero8, sx_sign8, sx_sign11
    } sext_op_t;

    typedef enum logic [1:0] {
        dst_rd_r,  // R-format destination in instr[4:2].
        dst_rd_i,  // I-format destination in instr[7:5].
        dst_rs,    // Source field instr[10:8] written back.
        dst_r7     // Link register.
    } wr_reg_sel_t;

    typedef enum logic [2:0] {
        wb_alu, wb_mem, wb_imm, wb_pc2, wb_set, wb_btr, wb_slbi
    } wr_sel_t;

    // Order matches instr[12:11] of seq, slt, sle and sco.
    typedef enum logic [1:0] {
        set_eq, set_lt, set_le, set_co
    } set_sel_t;

endpackage

// ==== hw/reg_file.sv ====
// Eight-word register file, one synchronous write port, two async reads.
// No write-to-read bypass: a write shows on the reads after its edge.
// Synchronous reset clears every entry and wins over a write.
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [isa_pkg::reg_addr_w-1:0] rd_addr_1,
    input  logic [isa_pkg::reg_addr_w-1:0] rd_addr_2,
    input  logic [isa_pkg::reg_addr_w-1:0] wr_addr,
    input  logic                           wr_en,
    input  logic [isa_pkg::data_w-1:0]     wr_data,
    output logic [isa_pkg::data_w-1:0]     rd_data_1,
    output logic [isa_pkg::data_w-1:0]     rd_data_2
);
    import isa_pkg::*;

    logic [data_w-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;  // One entry per edge.
        end
    end

    // The two read ports are independent.
    assign rd_data_1 = regs[rd_addr_1];
    assign rd_data_2 = regs[rd_addr_2];

endmodule

// ==== hw/sign_extend.sv ====
// Immediate former for the five formats of the ISA.
// Unused sext_op encodings give zero.
`timescale 1ns/1ps

module sign_extend (
    input  logic [isa_pkg::data_w-1:0] instr,
    input  isa_pkg::sext_op_t          sext_op,
    output logic [isa_pkg::data_w-1:0] imm
);
    import isa_pkg::*;

    always_comb begin
        case (sext_op)
            sx_zero5: begin
                imm = {{(data_w - 5){1'b0}}, instr[4:0]};  // Logic and shift amounts.
            end
            sx_sign5: begin
                imm = {{(data_w - 5){instr[4]}}, instr[4:0]};
            end
            sx_zero8: begin
                imm = {{(data_w - 8){1'b0}}, instr[7:0]};  // Low byte for slbi.
            end
            sx_sign8: begin
                imm = {{(data_w - 8){instr[7]}}, instr[7:0]};
            end
            sx_sign11: begin
                imm = {{(data_w - 11){instr[10]}}, instr[10:0]};  // Jump displacement.
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_decode -f decode_stage.f

# The verdict comes from the log, so a nonzero exit of the run is not fatal here.
./obj_dir/Vtb_decode > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "Simulation verdict: pass"
    exit 0
fi
echo "Simulation verdict: fail, see sim.log"
exit 1

// ==== verif/tb_decode.sv ====
// Self-checking testbench for the decode stage top.
// Inputs change just after a falling edge and outputs are sampled after
// the next falling edge. Build with --timing and --assert.
`timescale 1ns/1ps

module tb_decode;
    import isa_pkg::*;

    localparam int edge_limit = 50;  // Polls of 1 ns allowed per edge wait.

    logic        clk;
    logic        rst_n;
    logic [15:0] instr;
    logic [2:0]  rd_reg_1;
    logic [2:0]  rd_reg_2;
    logic        in_wr_en;
    logic [2:0]  in_wr_reg;
    logic [15:0] wr_data;
    logic [15:0] rd_data_1;
    logic [15:0] rd_data_2;
    logic [15:0] oprnd_2;
    logic [15:0] sext_imm;
    logic [1:0]  br_cnd_sel;
    logic [1:0]  set_sel;
    logic        out_wr_en;
    logic [2:0]  out_wr_reg;
    logic        mem_wr_en;
    logic        mem_en;
    logic [2:0]  wr_sel;
    logic        jmp_reg_instr;
    logic        jmp_instr;
    logic        br_instr;
    logic [2:0]  alu_op;
    logic        alu_inv_a;
    logic        alu_inv_b;
    logic        alu_cin;
    logic        alu_sign;
    logic        pc_en;
    logic        err;
    logic        err_exp;

    logic [31:0] seed = 32'hfa2bde8b;
    logic [15:0] model [8];  // Expected register contents.
    opcode_t     imm_ops [5] = '{op_addi, op_xori, op_beqz, op_slbi, op_j};
    opcode_t     dst_ops [10] = '{op_alu_r, op_seq, op_slt, op_addi, op_ld,
                                  op_lbi, op_slbi, op_stu, op_jal, op_jalr};
    alu_op_t     shift_ops [4] = '{alu_rol, alu_sll, alu_ror, alu_srl};
    string       current_test;
    int          test_errors;
    int          pass_tests;
    int          fail_tests;
    bit          timed_out;

    decode u_dut (.*);

    always #10 clk = ~clk;

    // Only siic and rti may ever raise err once out of reset.
    assign err_exp = (instr[15:11] == op_siic) || (instr[15:11] == op_rti);

    assert property (@(posedge clk) disable iff (!rst_n) err == err_exp)
    else begin
        $display("Mismatch %s err expected %0b actual %0b", current_test,
                 $sampled(err_exp), $sampled(err));
        test_errors++;
    end

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic [15:0] imm_rule(opcode_t op, logic [15:0] i);
        case (op)
            op_addi: return 16'($signed(i[4:0]));
            op_xori: return 16'(i[4:0]);
            op_beqz: return 16'($signed(i[7:0]));
            op_slbi: return 16'(i[7:0]);
            op_j:    return 16'($signed(i[10:0]));
            default: return 16'h0000;
        endcase
    endfunction

    function automatic logic [2:0] dest_rule(opcode_t op, logic [15:0] i);
        if (op inside {op_alu_r, op_seq, op_slt}) return i[4:2];
        if (op inside {op_addi, op_ld}) return i[7:5];
        if (op inside {op_jal, op_jalr}) return 3'd7;
        return i[10:8];  // lbi, slbi and stu.
    endfunction

    // Writeback source named by each member of wr_sel_t.
    function automatic wr_sel_t wb_source(opcode_t op);
        case (op)
            op_ld:                          return wb_mem;
            op_lbi:                         return wb_imm;
            op_slbi:                        return wb_slbi;
            op_btr:                         return wb_btr;
            op_jal, op_jalr:                return wb_pc2;
            op_seq, op_slt, op_sle, op_sco: return wb_set;
            default:                        return wb_alu;
        endcase
    endfunction

    function automatic set_sel_t set_rule(opcode_t op);
        case (op)
            op_slt:  return set_lt;
            op_sle:  return set_le;
            op_sco:  return set_co;
            default: return set_eq;
        endcase
    endfunction

    task automatic next_fall();
        int n;
        n = 0;
        if (timed_out) return;
        while (clk !== 1'b1 && n < edge_limit) begin
            #1;
            n++;
        end
        while (clk !== 1'b0 && n < edge_limit) begin
            #1;
            n++;
        end
        if (n >= edge_limit) begin
            $display("Timeout in %s: no falling clock edge within %0d ns", current_test, n);
            timed_out = 1'b1;
        end
    endtask

    task automatic apply(logic [15:0] i);
        instr = i;
        next_fall();
    endtask

    task automatic expect_eq(string what, logic [15:0] exp, logic [15:0] act);
        if (timed_out) return;
        assert (act === exp) else begin
            $display("Mismatch %s %s expected %h actual %h", current_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic begin_test(string name);
        current_test = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0 && !timed_out) begin
            $display("%s: ok", current_test);
            pass_tests++;
        end else begin
            $display("%s: %0d error(s)", current_test, test_errors);
            fail_tests++;
        end
    endtask

    // Packs the ALU controls as {alu_op, inv_a, inv_b, cin, sign}.
    task automatic alu_check(string what, logic [15:0] i, logic [6:0] exp);
        apply(i);
        expect_eq(what, 16'(exp), 16'({alu_op, alu_inv_a, alu_inv_b, alu_cin, alu_sign}));
    endtask

    initial begin
        opcode_t     op;
        logic [31:0] r;
        logic        wr_exp;
        clk = 1'b0;
        rst_n = 1'b0;
        instr = {op_nop, 11'd0};  // NOP keeps the write enables low.
        rd_reg_1 = '0;
        rd_reg_2 = '0;
        in_wr_en = 1'b0;
        in_wr_reg = '0;
        wr_data = '0;
        #0.5;

        begin_test("reset");
        repeat (5) next_fall();
        rst_n = 1'b1;
        for (int a = 0; a < 8; a++) begin
            model[a] = '0;
            rd_reg_1 = 3'(a);
            rd_reg_2 = 3'(7 - a);
            next_fall();
            expect_eq("rd_data_1", 16'h0000, rd_data_1);
            expect_eq("rd_data_2", 16'h0000, rd_data_2);
        end
        end_test();

        begin_test("write_read");
        for (int a = 0; a < 8; a++) begin
            r = next_rand();
            model[a] = r[15:0];
            in_wr_en = 1'b1;
            in_wr_reg = 3'(a);
            wr_data = r[15:0];
            rd_reg_1 = 3'(a);
            rd_reg_2 = 3'(a);
            next_fall();
            expect_eq("rd_data_1", model[a], rd_data_1);
            expect_eq("rd_data_2", model[a], rd_data_2);
            in_wr_en = 1'b0;  // Disabled write aimed at the word just stored.
            in_wr_reg = 3'(a);
            wr_data = ~model[a];
            rd_reg_2 = 3'(a + 1);
            next_fall();
            expect_eq("rd_data_1 idle", model[a], rd_data_1);
            expect_eq("rd_data_2 idle", model[(a + 1) % 8], rd_data_2);
        end
        end_test();

        begin_test("immediates");
        foreach (imm_ops[k]) begin
            repeat (8) begin
                r = next_rand();
                rd_reg_2 = r[13:11];
                apply({imm_ops[k], r[10:0]});
                expect_eq("sext_imm", imm_rule(imm_ops[k], instr), sext_imm);
                if (imm_ops[k] inside {op_addi, op_xori, op_slbi}) begin
                    expect_eq("oprnd_2 imm", imm_rule(imm_ops[k], instr), oprnd_2);
                end else begin
                    expect_eq("oprnd_2 reg", model[rd_reg_2], oprnd_2);
                end
            end
        end
        repeat (8) begin
            r = next_rand();
            rd_reg_2 = r[13:11];
            apply({op_alu_r, r[10:0]});
            expect_eq("oprnd_2 alu_r", model[rd_reg_2], oprnd_2);
        end
        end_test();

        begin_test("destination");
        foreach (dst_ops[k]) begin
            repeat (4) begin
                r = next_rand();
                apply({dst_ops[k], r[10:0]});
                expect_eq("out_wr_reg", 16'(dest_rule(dst_ops[k], instr)), 16'(out_wr_reg));
            end
        end
        end_test();

        begin_test("controls");
        for (int o = 0; o < 32; o++) begin
            op = opcode_t'(o[4:0]);
            r = next_rand();
            apply({o[4:0], r[10:0]});
            wr_exp = !(op inside {op_halt, op_nop, op_st, op_beqz, op_bnez, op_bltz,
                                  op_bgez, op_j, op_jr});
            expect_eq("err", 16'(op inside {op_siic, op_rti}), 16'(err));
            expect_eq("pc_en", 16'(op != op_halt), 16'(pc_en));
            expect_eq("out_wr_en", 16'(wr_exp), 16'(out_wr_en));
            if (wr_exp) begin
                expect_eq("wr_sel", 16'(wb_source(op)), 16'(wr_sel));
            end
            if (op inside {op_seq, op_slt, op_sle, op_sco}) begin
                expect_eq("set_sel", 16'(set_rule(op)), 16'(set_sel));
            end
            expect_eq("mem_en", 16'(op inside {op_st, op_ld, op_stu}), 16'(mem_en));
            expect_eq("mem_wr_en", 16'(op inside {op_st, op_stu}), 16'(mem_wr_en));
            expect_eq("br_instr", 16'(op inside {op_beqz, op_bnez, op_bltz, op_bgez}),
                      16'(br_instr));
            expect_eq("jmp_instr", 16'(op inside {op_j, op_jal}), 16'(jmp_instr));
            expect_eq("jmp_reg_instr", 16'(op inside {op_jr, op_jalr}), 16'(jmp_reg_instr));
            expect_eq("br_cnd_sel", 16'(instr[12:11]), 16'(br_cnd_sel));
        end
        end_test();

        begin_test("alu_controls");
        r = next_rand();
        alu_check("subi", {op_subi, r[10:0]}, {alu_add, 4'b1010});
        alu_check("sub", {op_alu_r, r[10:2], 2'b01}, {alu_add, 4'b1010});
        alu_check("andni", {op_andni, r[10:0]}, {alu_and, 4'b0100});
        alu_check("andn", {op_alu_r, r[10:2], 2'b11}, {alu_and, 4'b0100});
        alu_check("slt", {op_slt, r[10:0]}, {alu_add, 4'b0111});
        foreach (shift_ops[k]) begin
            alu_check("shift_r", {op_shift_r, r[10:2], 2'(k)}, {shift_ops[k], 4'b0000});
        end
        end_test();

        $display("Tests passed %0d, tests failed %0d", pass_tests, fail_tests);
        if (!timed_out && fail_tests == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
